// File: verilog/sparcPkg.sv
package sparcPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0]    word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    // Same bit order as the PSR icc field
    typedef struct packed {
        logic n;  // Negative
        logic z;  // Zero
        logic v;  // Signed overflow
        logic c;  // Carry out or borrow
    } condCodes_t;

    typedef enum logic [3:0] {
        opAdd, opAddx, opSub, opSubx,
        opAnd, opAndn, opOr, opOrn, opXor, opXnor,
        opSll, opSrl, opSra,
        opPassB                // sethi
    } aluOp_t;

    // Values are the Bicc cond field
    typedef enum logic [3:0] {
        condBn   = 4'b0000, condBe  = 4'b0001, condBle  = 4'b0010, condBl   = 4'b0011,
        condBleu = 4'b0100, condBcs = 4'b0101, condBneg = 4'b0110, condBvs  = 4'b0111,
        condBa   = 4'b1000, condBne = 4'b1001, condBg   = 4'b1010, condBge  = 4'b1011,
        condBgu  = 4'b1100, condBcc = 4'b1101, condBpos = 4'b1110, condBvc  = 4'b1111
    } branchCond_t;

    typedef enum logic [1:0] {
        fmtBranch = 2'b00,     // Bicc and sethi
        fmtCall   = 2'b01,
        fmtArith  = 2'b10,
        fmtMemory = 2'b11
    } instrFormat_t;

    localparam int opMsb     = 31;
    localparam int opLsb     = 30;
    localparam int rdMsb     = 29;
    localparam int rdLsb     = 25;
    localparam int condMsb   = 28;  // Bit 29 is the annul bit, ignored here
    localparam int condLsb   = 25;
    localparam int op2Msb    = 24;
    localparam int op2Lsb    = 22;
    localparam int op3Msb    = 24;
    localparam int op3Lsb    = 19;
    localparam int rs1Msb    = 18;
    localparam int rs1Lsb    = 14;
    localparam int iBitPos   = 13;
    localparam int simm13Msb = 12;
    localparam int simm13Lsb = 0;
    localparam int rs2Msb    = 4;
    localparam int rs2Lsb    = 0;
    localparam int imm22Msb  = 21;
    localparam int imm22Lsb  = 0;

endpackage

// File: verilog/stageIf.sv
`timescale 1ns/1ps

// Decode register to execute
interface execBundle import sparcPkg::*; ();
    logic        valid;
    aluOp_t      aluOp;
    word_t       opA;
    word_t       opB;
    regAddr_t    rd;
    logic        writeEn;   // Already low for rd 0
    logic        modifyCc;
    logic        isBranch;
    branchCond_t cond;

    modport decodeSide (output valid, aluOp, opA, opB, rd, writeEn, modifyCc, isBranch, cond);
    modport executeSide (input valid, aluOp, opA, opB, rd, writeEn, modifyCc, isBranch, cond);
endinterface

// Execute register to write-back, also read by decode for forwarding
interface resultBundle import sparcPkg::*; ();
    logic     valid;
    regAddr_t rd;
    word_t    data;
    logic     writeEn;
    word_t    aluNow;       // Combinational ALU output of the instruction in execute

    modport executeSide (output valid, rd, data, writeEn, aluNow);
    modport decodeSide (input valid, rd, data, writeEn, aluNow);
    modport resultSide (input valid, rd, data, writeEn);
endinterface

// File: verilog/instrDecode.sv
`timescale 1ns/1ps

module instrDecode import sparcPkg::*;
(
    input  logic     Clk,
    input  logic     rstN,
    input  logic     instrValid,
    input  word_t    instr,
    output regAddr_t rs1Addr,
    output regAddr_t rs2Addr,
    input  word_t    rs1Data,
    input  word_t    rs2Data,
    execBundle.decodeSide   exec,
    resultBundle.decodeSide res
);

    instrFormat_t fmt;
    logic [2:0]   op2;
    logic [5:0]   op3;
    regAddr_t     rd;
    word_t        simm13Ext;
    word_t        fwdA;
    word_t        fwdB;
    logic         decValid;
    logic         decIsBranch;
    logic         decWriteEn;
    aluOp_t       decOp;
    word_t        decOpB;

    // Youngest producer wins, the register file is the fallback
    function automatic word_t forwardOperand(input regAddr_t addr, input word_t rfData);
        word_t value;
        value = rfData;
        if (res.valid && res.writeEn && (res.rd == addr))
            value = res.data;      // Reaches write-back at this edge
        if (exec.valid && exec.writeEn && (exec.rd == addr))
            value = res.aluNow;    // Leaves execute at this edge
        return value;
    endfunction

    assign fmt       = instrFormat_t'(instr[opMsb:opLsb]);
    assign op2       = instr[op2Msb:op2Lsb];
    assign op3       = instr[op3Msb:op3Lsb];
    assign rd        = instr[rdMsb:rdLsb];
    assign rs1Addr   = instr[rs1Msb:rs1Lsb];
    assign rs2Addr   = instr[rs2Msb:rs2Lsb];
    assign simm13Ext = {{(dataWidth - 13){instr[simm13Msb]}}, instr[simm13Msb:simm13Lsb]};

    always_comb
    begin
        fwdA = forwardOperand(rs1Addr, rs1Data);
        fwdB = forwardOperand(rs2Addr, rs2Data);
    end

    always_comb
    begin
        decValid    = 1'b0;
        decIsBranch = 1'b0;
        decOp       = opAdd;
        decOpB      = instr[iBitPos] ? simm13Ext : fwdB;
        case (fmt)
            fmtBranch:
            begin
                if (op2 == 3'b010)
                begin
                    decValid    = 1'b1;    // Bicc
                    decIsBranch = 1'b1;
                end
                else if (op2 == 3'b100)
                begin
                    decValid = 1'b1;       // sethi
                    decOp    = opPassB;
                    decOpB   = {instr[imm22Msb:imm22Lsb], 10'b0};
                end
            end
            fmtArith:
            begin
                decValid = 1'b1;
                case (op3 & 6'b101111)     // Bit 4 only selects the cc variant
                    6'b000000: decOp = opAdd;
                    6'b000001: decOp = opAnd;
                    6'b000010: decOp = opOr;
                    6'b000011: decOp = opXor;
                    6'b000100: decOp = opSub;
                    6'b000101: decOp = opAndn;
                    6'b000110: decOp = opOrn;
                    6'b000111: decOp = opXnor;
                    6'b001000: decOp = opAddx;
                    6'b001100: decOp = opSubx;
                    6'b100101: decOp = opSll;
                    6'b100110: decOp = opSrl;
                    6'b100111: decOp = opSra;
                    default:   decValid = 1'b0;
                endcase
                if (op3[5] && op3[4])
                    decValid = 1'b0;       // No cc form of the shifts
            end
            fmtCall, fmtMemory: ;          // Not decoded, no result
            default: ;
        endcase
        decWriteEn = decValid && !decIsBranch && (rd != '0);
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            exec.valid    <= 1'b0;
            exec.writeEn  <= 1'b0;
            exec.modifyCc <= 1'b0;
            exec.isBranch <= 1'b0;
        end
        else
        begin
            exec.valid    <= instrValid && decValid;
            exec.writeEn  <= instrValid && decWriteEn;
            exec.modifyCc <= instrValid && decValid && (fmt == fmtArith) && !op3[5] && op3[4];
            exec.isBranch <= instrValid && decIsBranch;
        end
    end

    always_ff @(posedge Clk)
    begin
        exec.aluOp <= decOp;
        exec.opA   <= fwdA;
        exec.opB   <= decOpB;
        exec.rd    <= rd;
        exec.cond  <= branchCond_t'(instr[condMsb:condLsb]);
    end

endmodule

// File: verilog/aluExecute.sv
`timescale 1ns/1ps

module aluExecute import sparcPkg::*;
(
    input  logic       Clk,
    input  logic       rstN,
    execBundle.executeSide   exec,
    resultBundle.executeSide res,
    output condCodes_t condCodes,
    output logic       branchValid,
    output logic       branchTaken
);

    localparam int msb = dataWidth - 1;

    logic [dataWidth:0] sumWide;    // Extra bit holds carry or borrow
    logic               carryIn;
    word_t              aluResult;
    condCodes_t         aluFlags;
    logic               condTrue;

    assign carryIn = ((exec.aluOp == opAddx) || (exec.aluOp == opSubx)) && condCodes.c;

    always_comb
    begin
        sumWide    = '0;
        aluResult  = '0;
        aluFlags.v = 1'b0;
        aluFlags.c = 1'b0;
        case (exec.aluOp)
            opAdd, opAddx:
            begin
                sumWide    = {1'b0, exec.opA} + {1'b0, exec.opB} + {{dataWidth{1'b0}}, carryIn};
                aluResult  = sumWide[msb:0];
                aluFlags.c = sumWide[dataWidth];
                aluFlags.v = (exec.opA[msb] == exec.opB[msb]) && (aluResult[msb] != exec.opA[msb]);
            end
            opSub, opSubx:
            begin
                sumWide    = {1'b0, exec.opA} - {1'b0, exec.opB} - {{dataWidth{1'b0}}, carryIn};
                aluResult  = sumWide[msb:0];
                aluFlags.c = sumWide[dataWidth];   // Borrow
                aluFlags.v = (exec.opA[msb] != exec.opB[msb]) && (aluResult[msb] != exec.opA[msb]);
            end
            opAnd:   aluResult = exec.opA & exec.opB;
            opAndn:  aluResult = exec.opA & ~exec.opB;
            opOr:    aluResult = exec.opA | exec.opB;
            opOrn:   aluResult = exec.opA | ~exec.opB;
            opXor:   aluResult = exec.opA ^ exec.opB;
            opXnor:  aluResult = exec.opA ^ ~exec.opB;
            opSll:   aluResult = exec.opA << exec.opB[4:0];
            opSrl:   aluResult = exec.opA >> exec.opB[4:0];
            opSra:   aluResult = word_t'($signed(exec.opA) >>> exec.opB[4:0]);
            default: aluResult = exec.opB;         // sethi
        endcase
        aluFlags.n = aluResult[msb];
        aluFlags.z = (aluResult == '0);
    end

    assign res.aluNow = aluResult;

    // Bicc rules against the status register
    always_comb
    begin
        case (exec.cond)
            condBa:   condTrue = 1'b1;
            condBn:   condTrue = 1'b0;
            condBne:  condTrue = !condCodes.z;
            condBe:   condTrue = condCodes.z;
            condBg:   condTrue = !(condCodes.z || (condCodes.n ^ condCodes.v));
            condBle:  condTrue = condCodes.z || (condCodes.n ^ condCodes.v);
            condBge:  condTrue = !(condCodes.n ^ condCodes.v);
            condBl:   condTrue = condCodes.n ^ condCodes.v;
            condBgu:  condTrue = !condCodes.c && !condCodes.z;
            condBleu: condTrue = condCodes.c || condCodes.z;
            condBcc:  condTrue = !condCodes.c;
            condBcs:  condTrue = condCodes.c;
            condBpos: condTrue = !condCodes.n;
            condBneg: condTrue = condCodes.n;
            condBvc:  condTrue = !condCodes.v;
            condBvs:  condTrue = condCodes.v;
            default:  condTrue = 1'b0;
        endcase
    end

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            condCodes   <= '0;
            res.valid   <= 1'b0;
            res.writeEn <= 1'b0;
            branchValid <= 1'b0;
            branchTaken <= 1'b0;
        end
        else
        begin
            if (exec.valid && exec.modifyCc)
                condCodes <= aluFlags;
            res.valid   <= exec.valid;
            res.writeEn <= exec.valid && exec.writeEn;
            branchValid <= exec.valid && exec.isBranch;
            branchTaken <= exec.valid && exec.isBranch && condTrue;
        end
    end

    always_ff @(posedge Clk)
    begin
        res.rd   <= exec.rd;
        res.data <= aluResult;
    end

endmodule

// File: verilog/resultStage.sv
`timescale 1ns/1ps

module resultStage import sparcPkg::*;
(
    input  logic     Clk,
    input  logic     rstN,
    resultBundle.resultSide res,
    input  regAddr_t rs1Addr,
    input  regAddr_t rs2Addr,
    output word_t    rs1Data,
    output word_t    rs2Data,
    output logic     resultValid,
    output regAddr_t resultRd,
    output word_t    resultData
);

    localparam int regCount = 2 ** regAddrWidth;

    word_t regFile [1:regCount-1];  // r0 has no storage
    logic  writeNow;

    assign writeNow = res.valid && res.writeEn && (res.rd != '0);

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int idx = 1; idx < regCount; idx++)
                regFile[idx] <= '0;
        end
        else if (writeNow)
        begin
            regFile[res.rd] <= res.data;
        end
    end

    // Read ports see the old value during the write cycle
    // decode forwards res.data for that case
    assign rs1Data = (rs1Addr == '0) ? '0 : regFile[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regFile[rs2Addr];

    // Shown one cycle ahead of the register file update
    assign resultValid = writeNow;
    assign resultRd    = res.rd;
    assign resultData  = res.data;

endmodule

// File: verilog/sparcCore.sv
`timescale 1ns/1ps

module sparcCore import sparcPkg::*;
(
    input  logic       Clk,
    input  logic       rstN,
    input  logic       instrValid,
    input  word_t      instr,
    output logic       resultValid,
    output regAddr_t   resultRd,
    output word_t      resultData,
    output logic       branchValid,
    output logic       branchTaken,
    output condCodes_t condCodes
);

    regAddr_t rs1Addr;
    regAddr_t rs2Addr;
    word_t    rs1Data;
    word_t    rs2Data;

    execBundle   execLink ();
    resultBundle resLink ();

    instrDecode instrDecode_inst (
        .Clk        (Clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .exec       (execLink.decodeSide),
        .res        (resLink.decodeSide)
    );

    aluExecute aluExecute_inst (
        .Clk         (Clk),
        .rstN        (rstN),
        .exec        (execLink.executeSide),
        .res         (resLink.executeSide),
        .condCodes   (condCodes),
        .branchValid (branchValid),
        .branchTaken (branchTaken)
    );

    resultStage resultStage_inst (
        .Clk         (Clk),
        .rstN        (rstN),
        .res         (resLink.resultSide),
        .rs1Addr     (rs1Addr),
        .rs2Addr     (rs2Addr),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .resultValid (resultValid),
        .resultRd    (resultRd),
        .resultData  (resultData)
    );

endmodule

// File: tb/sparcCoreTb.sv
`timescale 1ns/1ps

module sparcCoreTb import sparcPkg::*;
();

    localparam int tableSize  = 80;
    localparam int directed   = 24;
    localparam int cycleLimit = (tableSize + 10) * 2;

    typedef enum logic [1:0] {kindNone, kindWrite, kindBranch} resultKind_t;

    typedef struct packed {
        logic        valid;
        word_t       instr;
        resultKind_t kind;
        regAddr_t    rd;
        word_t       data;
        logic        taken;
        condCodes_t  cc;      // Flags after this entry, in program order
    } entry_t;

    logic       Clk;
    logic       rstN;
    logic       instrValid;
    word_t      instr;
    logic       resultValid;
    regAddr_t   resultRd;
    word_t      resultData;
    logic       branchValid;
    logic       branchTaken;
    condCodes_t condCodes;

    entry_t      stimTable [tableSize];
    int          fillIdx;
    word_t       mdlReg [32];    // Reference register file, r0 never written
    condCodes_t  mdlCc;
    logic [31:0] rngState;
    int          cycleCount = 0;

    sparcCore sparcCore_inst (.*);

    always #10 Clk = ~Clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic wordCompare(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            abortRun($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic addrCompare(input string name, input regAddr_t got, input regAddr_t exp);
        if (got !== exp)
            abortRun($sformatf("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic flagsCompare(input string name, input condCodes_t got,
                                input condCodes_t exp);
        if (got !== exp)
            abortRun($sformatf("ERR t=%0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic bitCompare(input string name, input logic got, input logic exp);
        if (got !== exp)
            abortRun($sformatf("ERR t=%0t %s got %b expected %b", $time, name, got, exp));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic nextRandom(output logic [31:0] r);
        rngState = xorshift(rngState);
        r        = rngState;
    endtask

    function automatic logic [5:0] op3Of(input aluOp_t op);
        case (op)
            opAdd:   return 6'h00;
            opAnd:   return 6'h01;
            opOr:    return 6'h02;
            opXor:   return 6'h03;
            opSub:   return 6'h04;
            opAndn:  return 6'h05;
            opOrn:   return 6'h06;
            opXnor:  return 6'h07;
            opAddx:  return 6'h08;
            opSubx:  return 6'h0c;
            opSll:   return 6'h25;
            opSrl:   return 6'h26;
            default: return 6'h27;   // sra
        endcase
    endfunction

    // Codes 1xxx are the negation of codes 0xxx
    function automatic logic condHolds(input branchCond_t cond, input condCodes_t f);
        logic base;
        case (cond[2:0])
            3'd0:    base = 1'b0;
            3'd1:    base = f.z;
            3'd2:    base = f.z | (f.n ^ f.v);
            3'd3:    base = f.n ^ f.v;
            3'd4:    base = f.c | f.z;
            3'd5:    base = f.c;
            3'd6:    base = f.n;
            default: base = f.v;
        endcase
        return base ^ cond[3];
    endfunction

    function automatic word_t undecoded(input logic [1:0] pick, input word_t junk);
        word_t ins;
        ins = junk;
        case (pick)
            2'd0: ins[opMsb:opLsb] = 2'b01;    // call
            2'd1: ins[opMsb:opLsb] = 2'b11;    // Load or store
            2'd2:
            begin
                ins[opMsb:opLsb]   = 2'b10;
                ins[op3Msb:op3Lsb] = 6'h09;    // Unused op3
            end
            default:
            begin
                ins[opMsb:opLsb]   = 2'b10;
                ins[op3Msb:op3Lsb] = 6'h35;    // Shift with the cc bit set
            end
        endcase
        return ins;
    endfunction

    task automatic storeEntry(input logic valid, input word_t ins, input resultKind_t kind,
                              input regAddr_t rd, input word_t data, input logic taken);
        stimTable[fillIdx] = '{valid, ins, kind, rd, data, taken, mdlCc};
        fillIdx++;
    endtask

    task automatic rawEntry(input logic valid, input word_t ins);
        storeEntry(valid, ins, kindNone, '0, '0, 1'b0);
    endtask

    task automatic branchEntry(input branchCond_t cond);
        word_t ins;
        ins                    = '0;
        ins[condMsb:condLsb]   = cond;
        ins[op2Msb:op2Lsb]     = 3'b010;
        ins[imm22Msb:imm22Lsb] = 22'h3ffff0;   // Displacement has no effect here
        storeEntry(1'b1, ins, kindBranch, '0, '0, condHolds(cond, mdlCc));
    endtask

    task automatic sethiEntry(input regAddr_t rd, input logic [21:0] imm22);
        word_t ins;
        ins                    = '0;
        ins[rdMsb:rdLsb]       = rd;
        ins[op2Msb:op2Lsb]     = 3'b100;
        ins[imm22Msb:imm22Lsb] = imm22;
        if (rd != '0)
        begin
            mdlReg[rd] = {imm22, 10'b0};
            storeEntry(1'b1, ins, kindWrite, rd, {imm22, 10'b0}, 1'b0);
        end
        else
            storeEntry(1'b1, ins, kindNone, '0, '0, 1'b0);
    endtask

    task automatic arithEntry(input aluOp_t op, input logic cc, input regAddr_t rd,
                              input regAddr_t rs1, input logic useImm, input logic [12:0] src2);
        word_t       ins;
        word_t       a;
        word_t       b;
        word_t       r;
        logic        cin;
        logic        v;
        logic        c;
        ins                = '0;
        ins[opMsb:opLsb]   = 2'b10;
        ins[rdMsb:rdLsb]   = rd;
        ins[op3Msb:op3Lsb] = op3Of(op) | (cc ? 6'h10 : 6'h00);
        ins[rs1Msb:rs1Lsb] = rs1;
        ins[iBitPos]       = useImm;
        if (useImm)
            ins[simm13Msb:simm13Lsb] = src2;
        else
            ins[rs2Msb:rs2Lsb] = src2[4:0];
        a   = mdlReg[rs1];
        b   = useImm ? {{19{src2[12]}}, src2} : mdlReg[src2[4:0]];
        cin = ((op == opAddx) || (op == opSubx)) && mdlCc.c;
        v   = 1'b0;
        c   = 1'b0;
        case (op)
            opAdd, opAddx:
            begin
                r = a + b + {31'b0, cin};
                c = (a[31] & b[31]) | ((a[31] ^ b[31]) & ~r[31]);   // Carry out of bit 31
                v = (a[31] & b[31] & ~r[31]) | (~a[31] & ~b[31] & r[31]);
            end
            opSub, opSubx:
            begin
                r = a - b - {31'b0, cin};
                c = {1'b0, a} < ({1'b0, b} + {32'b0, cin});   // Borrow
                v = (a[31] & ~b[31] & ~r[31]) | (~a[31] & b[31] & r[31]);
            end
            opAnd:   r = a & b;
            opAndn:  r = a & ~b;
            opOr:    r = a | b;
            opOrn:   r = a | ~b;
            opXor:   r = a ^ b;
            opXnor:  r = ~(a ^ b);
            opSll:   r = a << b[4:0];
            opSrl:   r = a >> b[4:0];
            default: r = a[31] ? ~(~a >> b[4:0]) : (a >> b[4:0]);   // Sign fill
        endcase
        if (cc)
            mdlCc = {r[31], (r == '0), v, c};
        if (rd != '0)
        begin
            mdlReg[rd] = r;
            storeEntry(1'b1, ins, kindWrite, rd, r, 1'b0);
        end
        else
            storeEntry(1'b1, ins, kindNone, '0, '0, 1'b0);
    endtask

    task automatic fillDirected();
        arithEntry(opAdd, 1'b0, 5'd1, 5'd0, 1'b1, 13'd5);
        arithEntry(opAdd, 1'b0, 5'd2, 5'd1, 1'b1, 13'h1fff);    // Distance 1
        arithEntry(opSub, 1'b0, 5'd3, 5'd1, 1'b0, 13'd2);       // Distances 2 and 1
        sethiEntry(5'd4, 22'h3fffff);
        arithEntry(opOr, 1'b0, 5'd5, 5'd4, 1'b0, 13'd2);        // r2 at distance 3
        arithEntry(opAdd, 1'b1, 5'd6, 5'd4, 1'b0, 13'd4);       // Carry out
        arithEntry(opAddx, 1'b1, 5'd7, 5'd1, 1'b1, 13'd0);
        sethiEntry(5'd8, 22'h200000);
        arithEntry(opSub, 1'b1, 5'd0, 5'd8, 1'b1, 13'd1);       // Overflow, no write
        branchEntry(condBvs);
        branchEntry(condBvc);
        arithEntry(opSub, 1'b1, 5'd9, 5'd2, 1'b0, 13'd1);       // Borrow
        arithEntry(opSubx, 1'b1, 5'd10, 5'd1, 1'b1, 13'd0);
        arithEntry(opXnor, 1'b1, 5'd11, 5'd1, 1'b0, 13'd1);
        arithEntry(opAnd, 1'b1, 5'd12, 5'd11, 1'b0, 13'd0);     // Zero
        branchEntry(condBe);
        branchEntry(condBgu);
        arithEntry(opSll, 1'b0, 5'd13, 5'd1, 1'b1, 13'd4);
        arithEntry(opSra, 1'b0, 5'd14, 5'd8, 1'b0, 13'd2);
        arithEntry(opSrl, 1'b0, 5'd15, 5'd8, 1'b1, 13'd31);
        rawEntry(1'b1, 32'hc200_4000);                          // ld, not decoded
        arithEntry(opAndn, 1'b0, 5'd16, 5'd5, 1'b1, 13'h0ff);
        arithEntry(opOrn, 1'b0, 5'd17, 5'd0, 1'b0, 13'd0);
        rawEntry(1'b0, 32'h8200_6001);                          // Idle with an add on the bus
    endtask

    task automatic fillRandom();
        logic [31:0] r;
        logic [31:0] s;
        logic [3:0]  brCond;
        aluOp_t      op;
        brCond = 4'd0;
        for (int idx = directed; idx < tableSize; idx++)
        begin
            nextRandom(r);
            nextRandom(s);
            if (idx % 3 == 2)
            begin
                branchEntry(branchCond_t'(brCond));   // Walks all sixteen conditions
                brCond = brCond + 4'd1;
            end
            else if (r[2:0] == 3'd0)
                rawEntry(1'b0, s);
            else if (r[2:0] == 3'd1)
                rawEntry(1'b1, undecoded(r[4:3], s));
            else if (r[2:0] == 3'd2)
                sethiEntry({2'b0, r[7:5]}, s[21:0]);
            else
            begin
                op = aluOp_t'(4'(r[15:8] % 8'd13));
                arithEntry(op, r[16] && (op < opSll), {2'b0, r[19:17]}, {2'b0, r[22:20]},
                           r[23], r[23] ? s[12:0] : {10'b0, r[26:24]});
            end
        end
    endtask

    task automatic verifyEntry(input int idx);
        entry_t e;
        e = stimTable[idx];
        bitCompare("resultValid", resultValid, e.kind == kindWrite);
        bitCompare("branchValid", branchValid, e.kind == kindBranch);
        bitCompare("branchTaken", branchTaken, e.taken);
        if (e.kind == kindWrite)
        begin
            addrCompare("resultRd", resultRd, e.rd);
            wordCompare("resultData", resultData, e.data);
        end
        flagsCompare("condCodes", condCodes, e.cc);
    endtask

    always @(posedge Clk)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
            abortRun($sformatf("Run did not finish within %0d cycles", cycleLimit));
    end

    initial
    begin
        Clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        rngState   = 32'hdea3_2eec;
        fillIdx    = 0;
        mdlCc      = '0;
        for (int i = 0; i < 32; i++)
            mdlReg[i] = '0;
        fillDirected();
        fillRandom();
        repeat (4) @(negedge Clk);
        rstN = 1'b1;
        @(negedge Clk);
        bitCompare("resultValid", resultValid, 1'b0);   // Idle after reset
        bitCompare("branchValid", branchValid, 1'b0);
        bitCompare("branchTaken", branchTaken, 1'b0);
        flagsCompare("condCodes", condCodes, '0);
        // Each entry shows up two cycles after it is driven
        for (int step = 0; step < tableSize + 2; step++)
        begin
            if (step >= 2)
                verifyEntry(step - 2);
            if (step < tableSize)
            begin
                instrValid = stimTable[step].valid;
                instr      = stimTable[step].instr;
            end
            else
                instrValid = 1'b0;
            @(negedge Clk);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// File: flist.f
verilog/sparcPkg.sv
verilog/stageIf.sv
verilog/instrDecode.sv
verilog/aluExecute.sv
verilog/resultStage.sv
verilog/sparcCore.sv
tb/sparcCoreTb.sv

// File: Makefile
# Verilator build and run of the SPARC integer core testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module sparcCoreTb \
		-f flist.f -Mdir obj_dir

# Pass only when the pass message shows up in the simulator output
run: compile
	@out="$$(./obj_dir/VsparcCoreTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
